// ==== hw/csr_pkg.sv ====
package csr_pkg;

    // Field widths
    localparam int FFLAGS_BITS   = 5;
    localparam int FRM_BITS      = 3;
    localparam int FCSR_BITS     = FRM_BITS + FFLAGS_BITS;
    localparam int CSR_ADDR_BITS = 12;
    localparam int PERF_CTR_BITS = 64;
    localparam int UUID_BITS     = 44;

    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [31:0]              csr_data_t;
    typedef logic [FFLAGS_BITS-1:0]   fflags_t;
    typedef logic [FRM_BITS-1:0]      frm_t;
    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

    // Floating-point CSRs
    localparam csr_addr_t CSR_FFLAGS       = 12'h001;
    localparam csr_addr_t CSR_FRM          = 12'h002;
    localparam csr_addr_t CSR_FCSR         = 12'h003;

    // Machine CSRs, accepted and ignored except MISA
    localparam csr_addr_t CSR_SATP         = 12'h180;
    localparam csr_addr_t CSR_MSTATUS      = 12'h300;
    localparam csr_addr_t CSR_MISA         = 12'h301;
    localparam csr_addr_t CSR_MEDELEG      = 12'h302;
    localparam csr_addr_t CSR_MIDELEG      = 12'h303;
    localparam csr_addr_t CSR_MIE          = 12'h304;
    localparam csr_addr_t CSR_MTVEC        = 12'h305;
    localparam csr_addr_t CSR_MEPC         = 12'h341;
    localparam csr_addr_t CSR_PMPCFG0      = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0     = 12'h3B0;
    localparam csr_addr_t CSR_MNSTATUS     = 12'h744;

    // Counters
    localparam csr_addr_t CSR_MCYCLE       = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET     = 12'hB02;
    localparam csr_addr_t CSR_MCYCLE_H     = 12'hB80;
    localparam csr_addr_t CSR_MINSTRET_H   = 12'hB82;

    // Per-warp and per-core info
    localparam csr_addr_t CSR_WARP_ID      = 12'hCC1;
    localparam csr_addr_t CSR_CORE_ID      = 12'hCC2;
    localparam csr_addr_t CSR_CLUSTER_ID   = 12'hCC3;
    localparam csr_addr_t CSR_TMASK        = 12'hCC4;

    localparam csr_addr_t CSR_MVENDORID    = 12'hF11;
    localparam csr_addr_t CSR_MARCHID      = 12'hF12;
    localparam csr_addr_t CSR_MIMPID       = 12'hF13;

    localparam csr_addr_t CSR_NUM_THREADS  = 12'hFC0;
    localparam csr_addr_t CSR_NUM_WARPS    = 12'hFC1;
    localparam csr_addr_t CSR_NUM_CORES    = 12'hFC2;
    localparam csr_addr_t CSR_NUM_CLUSTERS = 12'hFC3;

    // Monitor windows, low and high halves
    localparam csr_addr_t CSR_MPM_BASE     = 12'hB00;
    localparam csr_addr_t CSR_MPM_BASE_H   = 12'hB80;
    localparam int        MPM_WINDOW       = 32;

    localparam csr_data_t VENDOR_ID        = 32'h0000_0056;
    localparam csr_data_t ARCH_ID          = 32'h0000_0001;
    localparam csr_data_t IMPL_ID          = 32'h0000_0100;
    // XLEN=32 plus I, M and F
    localparam csr_data_t MISA_VALUE       = 32'h4000_1120;

    // Index width for a count of items, never below one bit
    function automatic int idx_bits(input int count);
        if (count > 1) begin
            return $clog2(count);
        end
        return 1;
    endfunction

endpackage

// ==== hw/csr_fcsr_file.sv ====
`timescale 1ns/1ns

module csr_fcsr_file
    import csr_pkg::*;
#(
    parameter int NUM_WARPS  = 4,
    localparam int NW_BITS   = idx_bits(NUM_WARPS)
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 write_enable,
    input  logic [UUID_BITS-1:0] write_uuid,
    input  logic [NW_BITS-1:0]   write_wid,
    input  csr_addr_t            write_addr,
    input  csr_data_t            write_data,

    input  logic                 fpu_write_enable,
    input  logic [NW_BITS-1:0]   fpu_write_wid,
    input  fflags_t              fpu_write_fflags,
    input  logic [NW_BITS-1:0]   fpu_read_wid,
    output frm_t                 fpu_read_frm,

    input  logic [NW_BITS-1:0]   read_wid,
    output logic [FCSR_BITS-1:0] read_fcsr
);

    // Each entry is {frm, fflags}
    logic [NUM_WARPS-1:0][FCSR_BITS-1:0] fcsr;
    logic write_addr_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr <= '0;
        end else begin
            if (fpu_write_enable) begin
                fcsr[fpu_write_wid][FFLAGS_BITS-1:0] <=
                    fcsr[fpu_write_wid][FFLAGS_BITS-1:0] | fpu_write_fflags;
            end
            // Later assignment wins, so software overrides the FPU report
            if (write_enable) begin
                case (write_addr)
                    CSR_FFLAGS: begin
                        fcsr[write_wid][FFLAGS_BITS-1:0] <= write_data[FFLAGS_BITS-1:0];
                    end
                    CSR_FRM: begin
                        fcsr[write_wid][FCSR_BITS-1:FFLAGS_BITS] <= write_data[FRM_BITS-1:0];
                    end
                    CSR_FCSR: begin
                        fcsr[write_wid] <= write_data[FCSR_BITS-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (write_addr)
            CSR_FFLAGS,
            CSR_FRM,
            CSR_FCSR,
            CSR_SATP,
            CSR_MSTATUS,
            CSR_MNSTATUS,
            CSR_MEDELEG,
            CSR_MIDELEG,
            CSR_MIE,
            CSR_MTVEC,
            CSR_MEPC,
            CSR_PMPCFG0,
            CSR_PMPADDR0: write_addr_valid = 1'b1;
            default:      write_addr_valid = 1'b0;
        endcase
    end

    assign fpu_read_frm = fcsr[fpu_read_wid][FCSR_BITS-1:FFLAGS_BITS];
    assign read_fcsr    = fcsr[read_wid];

    write_addr_check: assert property (
        @(posedge clk) disable iff (reset)
        write_enable |-> write_addr_valid
    ) else $error("%t: invalid CSR write address 0x%0h (#%0d)", $time, write_addr, write_uuid);

endmodule

// ==== hw/csr_counters.sv ====
`timescale 1ns/1ns

module csr_counters
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // One pulse per retired instruction
    input  logic      commit_valid,

    output perf_ctr_t cycles,
    output perf_ctr_t instret
);

    perf_ctr_t cycles_r;
    perf_ctr_t instret_r;

    // Free running from the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            cycles_r <= '0;
        end else begin
            cycles_r <= cycles_r + perf_ctr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret_r <= '0;
        end else if (commit_valid) begin
            instret_r <= instret_r + perf_ctr_t'(1);
        end
    end

    assign cycles  = cycles_r;
    assign instret = instret_r;

    // At most one retirement per cycle
    instret_bound: assert property (
        @(posedge clk) disable iff (reset)
        instret_r <= cycles_r
    ) else $error("%t: instret %0d ahead of cycles %0d", $time, instret_r, cycles_r);

endmodule

// ==== hw/csr_read_mux.sv ====
`timescale 1ns/1ns

module csr_read_mux
    import csr_pkg::*;
#(
    parameter int NUM_WARPS    = 4,
    parameter int NUM_THREADS  = 4,
    parameter int CORE_ID      = 5,
    parameter int NUM_CORES    = 2,
    parameter int NUM_CLUSTERS = 3,
    localparam int NW_BITS     = idx_bits(NUM_WARPS)
) (
    input  logic                   clk,

    input  logic                   read_enable,
    input  logic [UUID_BITS-1:0]   read_uuid,
    input  logic [NW_BITS-1:0]     read_wid,
    input  logic [NUM_THREADS-1:0] read_tmask,
    input  csr_addr_t              read_addr,

    // FCSR entry of the read warp, {frm, fflags}
    input  logic [FCSR_BITS-1:0]   read_fcsr,
    input  perf_ctr_t              cycles,
    input  perf_ctr_t              instret,

    output csr_data_t              read_data_ro,
    output csr_data_t              read_data_rw
);

    csr_data_t read_data_ro_r;
    csr_data_t read_data_rw_r;
    logic      read_addr_valid;
    logic      in_mpm_window;

    assign in_mpm_window =
        (read_addr >= CSR_MPM_BASE && read_addr < CSR_MPM_BASE + MPM_WINDOW) ||
        (read_addr >= CSR_MPM_BASE_H && read_addr < CSR_MPM_BASE_H + MPM_WINDOW);

    always_comb begin
        read_data_ro_r  = '0;
        read_data_rw_r  = '0;
        read_addr_valid = 1'b1;
        case (read_addr)
            CSR_MVENDORID:    read_data_ro_r = VENDOR_ID;
            CSR_MARCHID:      read_data_ro_r = ARCH_ID;
            CSR_MIMPID:       read_data_ro_r = IMPL_ID;
            CSR_MISA:         read_data_ro_r = MISA_VALUE;

            CSR_FFLAGS:       read_data_rw_r = 32'(read_fcsr[FFLAGS_BITS-1:0]);
            CSR_FRM:          read_data_rw_r = 32'(read_fcsr[FCSR_BITS-1:FFLAGS_BITS]);
            CSR_FCSR:         read_data_rw_r = 32'(read_fcsr);

            CSR_WARP_ID:      read_data_ro_r = 32'(read_wid);
            CSR_CORE_ID:      read_data_ro_r = 32'(CORE_ID % NUM_CORES);
            CSR_CLUSTER_ID:   read_data_ro_r = 32'(CORE_ID / NUM_CORES);
            CSR_TMASK:        read_data_ro_r = 32'(read_tmask);
            CSR_NUM_THREADS:  read_data_ro_r = 32'(NUM_THREADS);
            CSR_NUM_WARPS:    read_data_ro_r = 32'(NUM_WARPS);
            CSR_NUM_CORES:    read_data_ro_r = 32'(NUM_CORES);
            CSR_NUM_CLUSTERS: read_data_ro_r = 32'(NUM_CLUSTERS);

            CSR_MCYCLE:       read_data_ro_r = cycles[31:0];
            CSR_MCYCLE_H:     read_data_ro_r = cycles[PERF_CTR_BITS-1:32];
            CSR_MINSTRET:     read_data_ro_r = instret[31:0];
            CSR_MINSTRET_H:   read_data_ro_r = instret[PERF_CTR_BITS-1:32];

            // Machine state not modelled here
            CSR_SATP,
            CSR_MSTATUS,
            CSR_MNSTATUS,
            CSR_MEDELEG,
            CSR_MIDELEG,
            CSR_MIE,
            CSR_MTVEC,
            CSR_MEPC,
            CSR_PMPCFG0,
            CSR_PMPADDR0:     read_data_ro_r = '0;

            // Rest of the monitor windows, including reserved slots, reads zero
            default:          read_addr_valid = in_mpm_window;
        endcase
    end

    assign read_data_ro = read_data_ro_r;
    assign read_data_rw = read_data_rw_r;

    read_addr_check: assert property (
        @(posedge clk) read_enable |-> read_addr_valid
    ) else $error("%t: invalid CSR read address 0x%0h (#%0d)", $time, read_addr, read_uuid);

endmodule

// ==== hw/csr_unit.sv ====
`timescale 1ns/1ns

module csr_unit
    import csr_pkg::*;
#(
    parameter int NUM_WARPS    = 4,
    parameter int NUM_THREADS  = 4,
    parameter int CORE_ID      = 5,
    parameter int NUM_CORES    = 2,
    parameter int NUM_CLUSTERS = 3,
    localparam int NW_BITS     = idx_bits(NUM_WARPS)
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   read_enable,
    input  logic [UUID_BITS-1:0]   read_uuid,
    input  logic [NW_BITS-1:0]     read_wid,
    input  logic [NUM_THREADS-1:0] read_tmask,
    input  csr_addr_t              read_addr,
    output csr_data_t              read_data_ro,
    output csr_data_t              read_data_rw,

    input  logic                   write_enable,
    input  logic [UUID_BITS-1:0]   write_uuid,
    input  logic [NW_BITS-1:0]     write_wid,
    input  csr_addr_t              write_addr,
    input  csr_data_t              write_data,

    input  logic                   fpu_write_enable,
    input  logic [NW_BITS-1:0]     fpu_write_wid,
    input  fflags_t                fpu_write_fflags,
    input  logic [NW_BITS-1:0]     fpu_read_wid,
    output frm_t                   fpu_read_frm,

    input  logic                   commit_valid
);

    logic [FCSR_BITS-1:0] read_fcsr;
    perf_ctr_t            cycles;
    perf_ctr_t            instret;

    csr_fcsr_file #(
        .NUM_WARPS (NUM_WARPS)
    ) fcsr_file (
        .clk              (clk),
        .reset            (reset),
        .write_enable     (write_enable),
        .write_uuid       (write_uuid),
        .write_wid        (write_wid),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .fpu_write_enable (fpu_write_enable),
        .fpu_write_wid    (fpu_write_wid),
        .fpu_write_fflags (fpu_write_fflags),
        .fpu_read_wid     (fpu_read_wid),
        .fpu_read_frm     (fpu_read_frm),
        .read_wid         (read_wid),
        .read_fcsr        (read_fcsr)
    );

    csr_counters counters (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .cycles       (cycles),
        .instret      (instret)
    );

    csr_read_mux #(
        .NUM_WARPS    (NUM_WARPS),
        .NUM_THREADS  (NUM_THREADS),
        .CORE_ID      (CORE_ID),
        .NUM_CORES    (NUM_CORES),
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) read_mux (
        .clk          (clk),
        .read_enable  (read_enable),
        .read_uuid    (read_uuid),
        .read_wid     (read_wid),
        .read_tmask   (read_tmask),
        .read_addr    (read_addr),
        .read_fcsr    (read_fcsr),
        .cycles       (cycles),
        .instret      (instret),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw)
    );

endmodule

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ns

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int NUM_WARPS       = 4;
    localparam int NUM_THREADS     = 4;
    localparam int NW_BITS         = $clog2(NUM_WARPS);
    localparam int INSTRET_TIMEOUT = 20;

    logic                   clk;
    logic                   reset;
    logic                   read_enable;
    logic [UUID_BITS-1:0]   read_uuid;
    logic [NW_BITS-1:0]     read_wid;
    logic [NUM_THREADS-1:0] read_tmask;
    csr_addr_t              read_addr;
    csr_data_t              read_data_ro;
    csr_data_t              read_data_rw;
    logic                   write_enable;
    logic [UUID_BITS-1:0]   write_uuid;
    logic [NW_BITS-1:0]     write_wid;
    csr_addr_t              write_addr;
    csr_data_t              write_data;
    logic                   fpu_write_enable;
    logic [NW_BITS-1:0]     fpu_write_wid;
    fflags_t                fpu_write_fflags;
    logic [NW_BITS-1:0]     fpu_read_wid;
    frm_t                   fpu_read_frm;
    logic                   commit_valid;

    // Expected FCSR per warp as {frm[7:5], fflags[4:0]}
    logic [7:0]           fcsr_model [NUM_WARPS];
    logic [31:0]          rng_state;
    logic [UUID_BITS-1:0] next_uuid;

    csr_unit DUT (
        .clk              (clk),
        .reset            (reset),
        .read_enable      (read_enable),
        .read_uuid        (read_uuid),
        .read_wid         (read_wid),
        .read_tmask       (read_tmask),
        .read_addr        (read_addr),
        .read_data_ro     (read_data_ro),
        .read_data_rw     (read_data_rw),
        .write_enable     (write_enable),
        .write_uuid       (write_uuid),
        .write_wid        (write_wid),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .fpu_write_enable (fpu_write_enable),
        .fpu_write_wid    (fpu_write_wid),
        .fpu_write_fflags (fpu_write_fflags),
        .fpu_read_wid     (fpu_read_wid),
        .fpu_read_frm     (fpu_read_frm),
        .commit_valid     (commit_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Warp seen by the FPU read port while the CSR read port reads wid
    function automatic logic [NW_BITS-1:0] paired_warp(input logic [NW_BITS-1:0] wid);
        return ~wid;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Drives a software write and an FPU report in one cycle and updates the model
    task automatic update_fcsr(input logic sw_en, input logic [NW_BITS-1:0] sw_wid,
                               input csr_addr_t addr, input csr_data_t data,
                               input logic fpu_en, input logic [NW_BITS-1:0] fpu_wid,
                               input fflags_t flags);
        @(posedge clk);
        write_enable     <= sw_en;
        write_wid        <= sw_wid;
        write_addr       <= addr;
        write_data       <= data;
        write_uuid       <= next_uuid;
        fpu_write_enable <= fpu_en;
        fpu_write_wid    <= fpu_wid;
        fpu_write_fflags <= flags;
        next_uuid = next_uuid + 1;
        if (fpu_en) begin
            fcsr_model[fpu_wid][4:0] = fcsr_model[fpu_wid][4:0] | flags;
        end
        if (sw_en && addr == CSR_FFLAGS) begin
            fcsr_model[sw_wid][4:0] = data[4:0];
        end else if (sw_en && addr == CSR_FRM) begin
            fcsr_model[sw_wid][7:5] = data[2:0];
        end else if (sw_en && addr == CSR_FCSR) begin
            fcsr_model[sw_wid] = data[7:0];
        end
        @(posedge clk);
        write_enable     <= 1'b0;
        fpu_write_enable <= 1'b0;
    endtask

    // Called just after a rising edge and samples at the next falling edge
    task automatic read_after_edge(input csr_addr_t addr, input logic [NW_BITS-1:0] wid,
                                   input logic [NUM_THREADS-1:0] tmask,
                                   output csr_data_t ro, output csr_data_t rw);
        read_enable  <= 1'b1;
        read_addr    <= addr;
        read_wid     <= wid;
        fpu_read_wid <= paired_warp(wid);
        read_tmask   <= tmask;
        read_uuid    <= next_uuid;
        next_uuid = next_uuid + 1;
        @(negedge clk);
        ro = read_data_ro;
        rw = read_data_rw;
    endtask

    task automatic read_csr(input csr_addr_t addr, input logic [NW_BITS-1:0] wid,
                            input logic [NUM_THREADS-1:0] tmask,
                            output csr_data_t ro, output csr_data_t rw);
        @(posedge clk);
        read_after_edge(addr, wid, tmask, ro, rw);
    endtask

    task automatic check_ro(input csr_addr_t addr, input logic [NW_BITS-1:0] wid,
                            input logic [NUM_THREADS-1:0] tmask, input csr_data_t expected);
        csr_data_t ro;
        csr_data_t rw;
        read_csr(addr, wid, tmask, ro, rw);
        check_value($sformatf("read_data_ro @0x%03h", addr), expected, ro);
        check_value($sformatf("read_data_rw @0x%03h", addr), 32'h0, rw);
    endtask

    task automatic check_fcsr_warp(input logic [NW_BITS-1:0] wid);
        csr_data_t ro;
        csr_data_t rw;
        read_csr(CSR_FCSR, wid, '1, ro, rw);
        check_value($sformatf("read_data_rw fcsr warp %0d", wid), {24'h0, fcsr_model[wid]}, rw);
        check_value($sformatf("read_data_ro fcsr warp %0d", wid), 32'h0, ro);
        check_value($sformatf("fpu_read_frm warp %0d", paired_warp(wid)),
                    32'(fcsr_model[paired_warp(wid)][7:5]), 32'(fpu_read_frm));
    endtask

    task automatic check_all_warps();
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_fcsr_warp(w[NW_BITS-1:0]);
        end
    endtask

    task automatic test_identification();
        logic [31:0] r;
        for (int i = 0; i < 2; i++) begin
            next_random(r);
            check_ro(CSR_MVENDORID, r[1:0], r[7:4], VENDOR_ID);
            check_ro(CSR_MARCHID, r[1:0], r[7:4], ARCH_ID);
            check_ro(CSR_MIMPID, r[1:0], r[7:4], IMPL_ID);
            check_ro(CSR_MISA, r[1:0], r[7:4], MISA_VALUE);
            check_ro(CSR_WARP_ID, r[1:0], r[7:4], 32'(r[1:0]));
            check_ro(CSR_TMASK, r[1:0], r[7:4], 32'(r[7:4]));
            // Core 5 of 2 per cluster sits in cluster 2 as core 1
            check_ro(CSR_CORE_ID, r[1:0], r[7:4], 32'd1);
            check_ro(CSR_CLUSTER_ID, r[1:0], r[7:4], 32'd2);
            check_ro(CSR_NUM_THREADS, r[1:0], r[7:4], 32'd4);
            check_ro(CSR_NUM_WARPS, r[1:0], r[7:4], 32'd4);
            check_ro(CSR_NUM_CORES, r[1:0], r[7:4], 32'd2);
            check_ro(CSR_NUM_CLUSTERS, r[1:0], r[7:4], 32'd3);
        end
    endtask

    task automatic test_fcsr_writes();
        logic [31:0] r;
        logic [31:0] data;
        csr_addr_t   addr;
        csr_data_t   ro;
        csr_data_t   rw;
        for (int i = 0; i < 12; i++) begin
            next_random(r);
            next_random(data);
            addr = (r[5:4] == 2'd0) ? CSR_FRM : (r[5:4] == 2'd1) ? CSR_FFLAGS : CSR_FCSR;
            update_fcsr(1'b1, r[1:0], addr, data, 1'b0, '0, '0);
            // Visible in the first cycle after the strobe
            read_after_edge(CSR_FFLAGS, r[1:0], '1, ro, rw);
            check_value("read_data_rw fflags", 32'(fcsr_model[r[1:0]][4:0]), rw);
            check_value("read_data_ro fflags", 32'h0, ro);
            check_value("fpu_read_frm", 32'(fcsr_model[paired_warp(r[1:0])][7:5]),
                        32'(fpu_read_frm));
            read_csr(CSR_FRM, r[1:0], '1, ro, rw);
            check_value("read_data_rw frm", 32'(fcsr_model[r[1:0]][7:5]), rw);
            check_all_warps();
        end
    endtask

    task automatic test_fpu_flags();
        logic [31:0] r;
        logic [31:0] data;
        next_random(r);
        next_random(data);
        update_fcsr(1'b1, r[1:0], CSR_FCSR, data & 32'hE0, 1'b0, '0, '0);
        for (int i = 0; i < 4; i++) begin
            next_random(data);
            update_fcsr(1'b0, '0, CSR_FFLAGS, '0, 1'b1, r[1:0], data[4:0]);
            check_fcsr_warp(r[1:0]);
        end
        // Software write wins over a report to the same warp
        next_random(data);
        update_fcsr(1'b1, r[1:0], CSR_FFLAGS, data, 1'b1, r[1:0], ~data[4:0]);
        check_fcsr_warp(r[1:0]);
        next_random(data);
        update_fcsr(1'b1, r[1:0], CSR_FRM, data, 1'b1, r[1:0] + 2'd1, data[12:8]);
        check_all_warps();
    endtask

    task automatic test_counters();
        logic [31:0] r;
        csr_data_t   ro;
        csr_data_t   rw;
        csr_data_t   start;
        int          k;
        int          n;
        int          polls;
        next_random(r);
        k = 3 + int'(r[3:0]);
        n = 1 + int'(r[6:4]);
        read_csr(CSR_MCYCLE, '0, '1, start, rw);
        repeat (k) @(posedge clk);
        read_after_edge(CSR_MCYCLE, '0, '1, ro, rw);
        check_value("read_data_ro mcycle", start + k, ro);
        check_ro(CSR_MCYCLE_H, '0, '1, 32'h0);
        read_csr(CSR_MINSTRET, '0, '1, start, rw);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            commit_valid <= 1'b1;
            @(posedge clk);
            commit_valid <= 1'b0;
            next_random(r);
            repeat (r[1:0]) @(posedge clk);
        end
        polls = 0;
        read_csr(CSR_MINSTRET, '0, '1, ro, rw);
        while (ro < start + n && polls < INSTRET_TIMEOUT) begin
            read_csr(CSR_MINSTRET, '0, '1, ro, rw);
            polls++;
        end
        assert (ro >= start + n) else begin
            $display("Timed out waiting for minstret to count %0d commit pulses", n);
            stop_on_failure();
        end
        check_value("read_data_ro minstret", start + n, ro);
        check_ro(CSR_MINSTRET_H, '0, '1, 32'h0);
    endtask

    task automatic test_ignored_addresses();
        csr_addr_t   ignored [10];
        logic [31:0] r;
        logic [31:0] data;
        ignored = '{CSR_SATP, CSR_MSTATUS, CSR_MNSTATUS, CSR_MEDELEG, CSR_MIDELEG,
                    CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0};
        foreach (ignored[i]) begin
            next_random(r);
            next_random(data);
            update_fcsr(1'b1, r[1:0], ignored[i], data, 1'b0, '0, '0);
            check_all_warps();
            check_ro(ignored[i], r[1:0], '1, 32'h0);
        end
        // Reserved monitor slots
        check_ro(12'hB05, '0, '1, 32'h0);
        check_ro(12'hB1F, '0, '1, 32'h0);
        check_ro(12'hB85, '0, '1, 32'h0);
    endtask

    initial begin
        csr_data_t ro;
        csr_data_t rw;
        rng_state        = 32'd12751;
        next_uuid        = '0;
        reset            = 1'b1;
        read_enable      = 1'b0;
        read_uuid        = '0;
        read_wid         = '0;
        read_tmask       = '0;
        read_addr        = '0;
        write_enable     = 1'b0;
        write_uuid       = '0;
        write_wid        = '0;
        write_addr       = '0;
        write_data       = '0;
        fpu_write_enable = 1'b0;
        fpu_write_wid    = '0;
        fpu_write_fflags = '0;
        fpu_read_wid     = '0;
        commit_valid     = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            fcsr_model[w] = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        read_after_edge(CSR_MCYCLE, '0, '1, ro, rw);
        check_value("read_data_ro mcycle after reset", 32'h0, ro);

        test_identification();
        test_fcsr_writes();
        test_fpu_flags();
        test_counters();
        test_ignored_addresses();

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== all.f ====
hw/csr_pkg.sv
hw/csr_fcsr_file.sv
hw/csr_counters.sv
hw/csr_read_mux.sv
hw/csr_unit.sv
verification/csr_unit_tb.sv
